//--- bp_top.f
rtl/bp_pkg.sv
rtl/bp_init_seq.sv
rtl/bp_btb.sv
rtl/bp_bht.sv
rtl/bp_lookup_stage.sv
rtl/bp_predict_stage.sv
rtl/bp_top.sv
sim/bp_tb.sv

//--- rtl/bp_bht.sv
`timescale 1ns/1ps

module bp_bht import bp_pkg::*; #(
    parameter int INDEX_BITS = 8
)
(
    input  logic                  clk,
    input  logic                  clr_valid,
    input  logic [INDEX_BITS-1:0] clr_index,
    input  logic                  train_valid,
    input  bp_train_t             train,
    input  logic                  init_done,
    input  logic                  rd_en,
    input  logic [INDEX_BITS-1:0] rd_index,
    output logic [1:0]            bht_rd
);

    localparam int DEPTH = 2 ** INDEX_BITS;

    logic [1:0] mem [DEPTH];

    logic [INDEX_BITS-1:0] train_index;
    logic [1:0]            cur_cnt;
    logic [1:0]            next_cnt;
    logic                  wr_en;
    logic [INDEX_BITS-1:0] wr_index;
    logic [1:0]            wr_cnt;

    assign train_index = train.pc[INDEX_BITS+1:2];
    assign cur_cnt     = mem[train_index];

    // Two-bit saturating update.
    always_comb
    begin
        if (train.taken)
        begin
            next_cnt = (cur_cnt == 2'd3) ? 2'd3 : cur_cnt + 2'd1;
        end
        else
        begin
            next_cnt = (cur_cnt == 2'd0) ? 2'd0 : cur_cnt - 2'd1;
        end
    end

    always_comb
    begin
        if (!init_done)
        begin
            wr_en    = clr_valid;
            wr_index = clr_index;
            wr_cnt   = 2'd0;
        end
        else
        begin
            wr_en    = train_valid;
            wr_index = train_index;
            wr_cnt   = next_cnt;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_index] <= wr_cnt;
        end
        if (rd_en)
        begin
            bht_rd <= mem[rd_index];
        end
    end

endmodule

//--- rtl/bp_btb.sv
`timescale 1ns/1ps

module bp_btb import bp_pkg::*; #(
    parameter int INDEX_BITS = 8
)
(
    input  logic                  clk,
    input  logic                  clr_valid,
    input  logic [INDEX_BITS-1:0] clr_index,
    input  logic                  train_valid,
    input  bp_train_t             train,
    input  logic                  init_done,
    input  logic                  rd_en,
    input  logic [INDEX_BITS-1:0] rd_index,
    output btb_entry_t            btb_rd
);

    localparam int DEPTH = 2 ** INDEX_BITS;

    btb_entry_t mem [DEPTH];

    logic                  wr_en;
    logic [INDEX_BITS-1:0] wr_index;
    btb_entry_t            wr_entry;

    // Clear sweep owns the port until init completes.
    always_comb
    begin
        if (!init_done)
        begin
            wr_en    = clr_valid;
            wr_index = clr_index;
            wr_entry = '0;
        end
        else
        begin
            // Only taken branches allocate or refresh an entry.
            wr_en           = train_valid && train.taken;
            wr_index        = train.pc[INDEX_BITS+1:2];
            wr_entry.valid  = 1'b1;
            wr_entry.tag    = train.pc[PC_W-1:2];
            wr_entry.target = train.target;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_index] <= wr_entry;
        end
    end

    // Read sees the old entry on a same cycle write.
    always_ff @(posedge clk)
    begin
        if (rd_en)
        begin
            btb_rd <= mem[rd_index];
        end
    end

endmodule

//--- rtl/bp_init_seq.sv
`timescale 1ns/1ps

module bp_init_seq #(
    parameter int INDEX_BITS = 8
)
(
    input  logic                  clk,
    input  logic                  rst_i,
    output logic                  clr_valid,
    output logic [INDEX_BITS-1:0] clr_index,
    output logic                  init_done
);

    localparam logic [INDEX_BITS-1:0] LAST_INDEX = '1;

    logic [INDEX_BITS-1:0] index_q;
    logic                  done_q;

    // Sweep runs until the last index has been written.
    assign clr_valid = ~done_q;
    assign clr_index = index_q;
    assign init_done = done_q;

    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            index_q <= '0;
            done_q  <= 1'b0;
        end
        else if (!done_q)
        begin
            index_q <= index_q + 1'b1;
            if (index_q == LAST_INDEX)
            begin
                // Flag goes high together with the final clear write.
                done_q <= 1'b1;
            end
        end
    end

endmodule

//--- rtl/bp_lookup_stage.sv
`timescale 1ns/1ps

module bp_lookup_stage import bp_pkg::*; #(
    parameter int INDEX_BITS = 8
)
(
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  req_valid,
    input  bp_req_t               req,
    input  logic                  accept_en,
    output logic                  req_ready,
    output logic                  rd_en,
    output logic [INDEX_BITS-1:0] rd_index,
    output logic                  s1_valid,
    output bp_req_t               s1_req,
    input  logic                  s2_ready
);

    logic accept;

    // Slot frees up when empty or when it drains this cycle.
    assign req_ready = accept_en && (!s1_valid || s2_ready);
    assign accept    = req_valid && req_ready;

    // Table reads launch on the accepting edge, so a stalled slot keeps its data.
    assign rd_en    = accept;
    assign rd_index = req.pc[INDEX_BITS+1:2];

    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            s1_valid <= 1'b0;
        end
        else
        begin
            s1_valid <= accept || (s1_valid && !s2_ready);
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            s1_req <= req;
        end
    end

endmodule

//--- rtl/bp_pkg.sv
package bp_pkg;

    parameter int PC_W  = 32;
    // Tags keep the whole word address so they do not depend on table depth.
    parameter int TAG_W = PC_W - 2;

    typedef logic [PC_W-1:0] pc_t;

    typedef struct packed
    {
        pc_t pc;
    } bp_req_t;

    typedef struct packed
    {
        pc_t  pc;
        pc_t  next_pc;
        logic hit;
        logic taken;
    } bp_pred_t;

    // Resolved branch outcome from the execute stage.
    typedef struct packed
    {
        pc_t  pc;
        pc_t  target;
        logic taken;
    } bp_train_t;

    typedef struct packed
    {
        logic             valid;
        logic [TAG_W-1:0] tag;
        pc_t              target;
    } btb_entry_t;

endpackage

//--- rtl/bp_predict_stage.sv
`timescale 1ns/1ps

module bp_predict_stage import bp_pkg::*;
(
    input  logic       clk,
    input  logic       rst_i,
    input  logic       s1_valid,
    input  bp_req_t    s1_req,
    output logic       s2_ready,
    input  btb_entry_t btb_rd,
    input  logic [1:0] bht_rd,
    output logic       pred_valid,
    output bp_pred_t   pred,
    input  logic       pred_ready
);

    logic     take;
    logic     hit;
    logic     taken;
    bp_pred_t pred_d;

    assign s2_ready = !pred_valid || pred_ready;
    assign take     = s1_valid && s2_ready;

    assign hit   = btb_rd.valid && (btb_rd.tag == s1_req.pc[PC_W-1:2]);
    // Counter values 2 and 3 mean taken.
    assign taken = hit && bht_rd[1];

    always_comb
    begin
        pred_d.pc      = s1_req.pc;
        pred_d.hit     = hit;
        pred_d.taken   = taken;
        pred_d.next_pc = taken ? btb_rd.target : s1_req.pc + pc_t'(4);
    end

    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            pred_valid <= 1'b0;
        end
        else if (s2_ready)
        begin
            pred_valid <= s1_valid;
        end
    end

    // Output is held while the consumer stalls.
    always_ff @(posedge clk)
    begin
        if (take)
        begin
            pred <= pred_d;
        end
    end

endmodule

//--- rtl/bp_top.sv
`timescale 1ns/1ps

module bp_top import bp_pkg::*; #(
    parameter int INDEX_BITS = 8
)
(
    input  logic      clk,
    input  logic      rst_i,
    input  logic      req_valid,
    output logic      req_ready,
    input  bp_req_t   req,
    output logic      pred_valid,
    input  logic      pred_ready,
    output bp_pred_t  pred,
    input  logic      train_valid,
    input  bp_train_t train,
    output logic      init_done
);

    logic                  clr_valid;
    logic [INDEX_BITS-1:0] clr_index;
    logic                  rd_en;
    logic [INDEX_BITS-1:0] rd_index;
    logic                  s1_valid;
    bp_req_t               s1_req;
    logic                  s2_ready;
    btb_entry_t            btb_rd;
    logic [1:0]            bht_rd;

    bp_init_seq #(
        .INDEX_BITS (INDEX_BITS)
    ) u_init_seq (
        .clk       (clk),
        .rst_i     (rst_i),
        .clr_valid (clr_valid),
        .clr_index (clr_index),
        .init_done (init_done)
    );

    bp_btb #(
        .INDEX_BITS (INDEX_BITS)
    ) u_btb (
        .clk         (clk),
        .clr_valid   (clr_valid),
        .clr_index   (clr_index),
        .train_valid (train_valid),
        .train       (train),
        .init_done   (init_done),
        .rd_en       (rd_en),
        .rd_index    (rd_index),
        .btb_rd      (btb_rd)
    );

    bp_bht #(
        .INDEX_BITS (INDEX_BITS)
    ) u_bht (
        .clk         (clk),
        .clr_valid   (clr_valid),
        .clr_index   (clr_index),
        .train_valid (train_valid),
        .train       (train),
        .init_done   (init_done),
        .rd_en       (rd_en),
        .rd_index    (rd_index),
        .bht_rd      (bht_rd)
    );

    // No lookups are taken until the tables are cleared.
    bp_lookup_stage #(
        .INDEX_BITS (INDEX_BITS)
    ) u_lookup (
        .clk       (clk),
        .rst_i     (rst_i),
        .req_valid (req_valid),
        .req       (req),
        .accept_en (init_done),
        .req_ready (req_ready),
        .rd_en     (rd_en),
        .rd_index  (rd_index),
        .s1_valid  (s1_valid),
        .s1_req    (s1_req),
        .s2_ready  (s2_ready)
    );

    bp_predict_stage u_predict (
        .clk        (clk),
        .rst_i      (rst_i),
        .s1_valid   (s1_valid),
        .s1_req     (s1_req),
        .s2_ready   (s2_ready),
        .btb_rd     (btb_rd),
        .bht_rd     (bht_rd),
        .pred_valid (pred_valid),
        .pred       (pred),
        .pred_ready (pred_ready)
    );

endmodule

//--- sim/bp_tb.sv
`timescale 1ns/1ps

module bp_tb import bp_pkg::*;
();

    localparam int INDEX_BITS = 8;
    localparam int NUM_TESTS  = 6;
    localparam int TIMEOUT    = (2 ** INDEX_BITS) * 2 + 200 * NUM_TESTS;

    logic      clk;
    logic      rst_i;
    logic      req_valid;
    logic      req_ready;
    bp_req_t   req;
    logic      pred_valid;
    logic      pred_ready;
    bp_pred_t  pred;
    logic      train_valid;
    bp_train_t train;
    logic      init_done;

    // Reference predictor state; a missing key means a cleared entry.
    int          m_cnt    [int];
    bit          m_valid  [int];
    logic [29:0] m_tag    [int];
    pc_t         m_target [int];

    pc_t pending_pc [$];

    bp_top #(
        .INDEX_BITS (INDEX_BITS)
    ) uut (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req         (req),
        .pred_valid  (pred_valid),
        .pred_ready  (pred_ready),
        .pred        (pred),
        .train_valid (train_valid),
        .train       (train),
        .init_done   (init_done)
    );

    always #2 clk = ~clk;

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped.");
    endtask

    task automatic check_value(input string name, input logic [95:0] got,
                               input logic [95:0] exp);
        string msg;
        if (got !== exp)
        begin
            msg = $sformatf("error %s got 0x%0h expected 0x%0h", name, got, exp);
            stop_with_failure(msg);
        end
    endtask

    function automatic bp_pred_t model_predict(input pc_t pc);
        int       idx;
        bp_pred_t p;
        idx       = pc[INDEX_BITS+1:2];
        p.pc      = pc;
        p.hit     = m_valid.exists(idx) && (m_tag[idx] == pc[31:2]);
        p.taken   = p.hit && m_cnt.exists(idx) && (m_cnt[idx] >= 2);
        p.next_pc = p.taken ? m_target[idx] : pc + 32'd4;
        return p;
    endfunction

    function automatic void model_train(input bp_train_t t);
        int idx;
        int c;
        idx = t.pc[INDEX_BITS+1:2];
        c   = m_cnt.exists(idx) ? m_cnt[idx] : 0;
        if (t.taken)
        begin
            c             = (c < 3) ? c + 1 : 3;
            m_valid[idx]  = 1'b1;
            m_tag[idx]    = t.pc[31:2];
            m_target[idx] = t.target;
        end
        else
        begin
            c = (c > 0) ? c - 1 : 0;
        end
        m_cnt[idx] = c;
    endfunction

    task automatic wait_init();
        int cycles;
        cycles = 0;
        while (init_done !== 1'b1)
        begin
            check_value("req_ready", req_ready, 0);
            @(posedge clk);
            #1;
            cycles++;
        end
        check_value("init_cycles", cycles, 2 ** INDEX_BITS);
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_i = 1'b1;
        repeat (4)
        begin
            @(posedge clk);
            #1;
            check_value("init_done", init_done, 0);
            check_value("req_ready", req_ready, 0);
        end
        @(negedge clk);
        rst_i = 1'b0;
        m_cnt.delete();
        m_valid.delete();
        m_tag.delete();
        m_target.delete();
        wait_init();
    endtask

    task automatic do_train(input pc_t pc, input pc_t target, input logic taken);
        @(negedge clk);
        train_valid  = 1'b1;
        train.pc     = pc;
        train.target = target;
        train.taken  = taken;
        model_train(train);
        @(negedge clk);
        train_valid = 1'b0;
    endtask

    // Sends every pending PC; with stall set, pred_ready follows a random pattern.
    task automatic do_lookup(input bit stall);
        bp_pred_t exp_q [$];
        int       acc_q [$];
        bp_pred_t exp;
        int       total;
        int       sent;
        int       got;
        int       cycle;
        total = pending_pc.size();
        sent  = 0;
        got   = 0;
        cycle = 0;
        while (got < total)
        begin
            @(negedge clk);
            req_valid  = (sent < total);
            req.pc     = (sent < total) ? pending_pc[sent] : '0;
            pred_ready = stall ? 1'($urandom % 2) : 1'b1;
            #1;
            if (pred_valid && pred_ready)
            begin
                if (exp_q.size() == 0)
                begin
                    stop_with_failure("A prediction arrived with no request outstanding.");
                end
                exp = exp_q.pop_front();
                check_value("pred.pc", pred.pc, exp.pc);
                check_value("pred.next_pc", pred.next_pc, exp.next_pc);
                check_value("pred.hit", pred.hit, exp.hit);
                check_value("pred.taken", pred.taken, exp.taken);
                if (!stall)
                begin
                    check_value("latency", cycle - acc_q[0], 2);
                end
                void'(acc_q.pop_front());
                got++;
            end
            if (req_valid && req_ready)
            begin
                exp_q.push_back(model_predict(pending_pc[sent]));
                acc_q.push_back(cycle);
                sent++;
            end
            cycle++;
        end
        @(negedge clk);
        req_valid  = 1'b0;
        pred_ready = 1'b1;
        // Nothing may be left in flight.
        repeat (3)
        begin
            @(negedge clk);
            #1;
            check_value("pred_valid", pred_valid, 0);
        end
        pending_pc.delete();
    endtask

    task automatic lookup_one(input pc_t pc);
        pending_pc.push_back(pc);
        do_lookup(1'b0);
    endtask

    initial
    begin
        repeat (TIMEOUT) @(posedge clk);
        stop_with_failure("Timeout: the tests did not finish in the expected time.");
    end

    initial
    begin
        pc_t pc_a;
        pc_t pc_b;
        pc_t burst [$];
        void'($urandom(30938));
        clk         = 1'b0;
        rst_i       = 1'b1;
        req_valid   = 1'b0;
        req         = '0;
        pred_ready  = 1'b1;
        train_valid = 1'b0;
        train       = '0;
        pc_a        = 32'h0000_1040;
        pc_b        = 32'h0040_1040;

        // Reset, sweep, and random lookups that all miss.
        apply_reset();
        repeat (8) pending_pc.push_back($urandom & 32'hffff_fffc);
        do_lookup(1'b0);

        // Two taken updates reach the taken state.
        do_train(pc_a, 32'h0000_2000, 1'b1);
        lookup_one(pc_a);
        do_train(pc_a, 32'h0000_2000, 1'b1);
        lookup_one(pc_a);

        // Saturate from 0, decay, then a taken step shows the floor held at 0.
        repeat (2) do_train(pc_a, 32'h0000_2000, 1'b0);
        repeat (5) do_train(pc_a, 32'h0000_2000, 1'b1);
        repeat (2) do_train(pc_a, 32'h0000_2000, 1'b0);
        lookup_one(pc_a);
        repeat (3) do_train(pc_a, 32'h0000_2000, 1'b0);
        lookup_one(pc_a);
        do_train(pc_a, 32'h0000_2000, 1'b1);
        lookup_one(pc_a);

        // Alias shares the index but not the tag.
        lookup_one(pc_b);
        do_train(pc_b, 32'h0000_3000, 1'b1);
        do_train(pc_b, 32'h0000_3000, 1'b1);
        lookup_one(pc_a);
        lookup_one(pc_b);

        // Burst under random back-pressure.
        burst.push_back(pc_b);
        burst.push_back(pc_a);
        repeat (6) burst.push_back($urandom & 32'hffff_fffc);
        do_train(burst[2], 32'h0000_4000, 1'b1);
        do_train(burst[2], 32'h0000_4000, 1'b1);
        foreach (burst[i]) pending_pc.push_back(burst[i]);
        do_lookup(1'b1);

        // A second reset clears everything trained.
        apply_reset();
        foreach (burst[i]) pending_pc.push_back(burst[i]);
        do_lookup(1'b0);

        $display("TEST PASS");
        $finish;
    end

endmodule
